//--- Bender.yml
package:
  name: maze_display

sources:
  - hdl/tft_pkg.sv
  - hdl/tft_spi.sv
  - hdl/tft_init.sv
  - hdl/sprite_draw.sv
  - hdl/display_ctrl.sv
  - hdl/maze_display.sv
  - target: test
    files:
      - tests/tb_maze_display.sv

//--- all.f
hdl/tft_pkg.sv
hdl/tft_spi.sv
hdl/tft_init.sv
hdl/sprite_draw.sv
hdl/display_ctrl.sv
hdl/maze_display.sv
tests/tb_maze_display.sv

//--- hdl/display_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module display_ctrl (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      draw,
	input  logic [tft_pkg::POS_W-1:0] player_x,
	input  logic [tft_pkg::POS_W-1:0] player_y,
	input  logic                      init_done,
	input  logic                      draw_done,
	input  logic                      spi_busy,
	input  logic [7:0]                init_data,
	input  logic                      init_dc,
	input  logic                      init_transmit,
	input  logic [7:0]                draw_data,
	input  logic                      draw_dc,
	input  logic                      draw_transmit,
	output logic                      init_enable,
	output logic                      draw_enable,
	output logic [tft_pkg::POS_W-1:0] draw_x,
	output logic [tft_pkg::POS_W-1:0] draw_y,
	output logic [7:0]                spi_data,
	output logic                      spi_dc,
	output logic                      spi_transmit,
	output logic                      busy
);

	tft_pkg::ctrl_state_e state;
	logic                 accept;

	assign accept = draw && (state == tft_pkg::IDLE) && !spi_busy;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state       <= tft_pkg::RESET;
			init_enable <= 1'b0;
			draw_enable <= 1'b0;
		end else begin
			init_enable <= 1'b0;
			draw_enable <= 1'b0;
			case (state)
				tft_pkg::RESET: begin
					init_enable <= 1'b1;
					state       <= tft_pkg::INIT;
				end
				tft_pkg::INIT: if (init_done) state <= tft_pkg::IDLE;
				tft_pkg::IDLE: begin
					if (accept) begin
						draw_enable <= 1'b1;
						state       <= tft_pkg::DRAW;
					end
				end
				tft_pkg::DRAW: if (draw_done) state <= tft_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			draw_x <= player_x;
			draw_y <= player_y;
		end
	end

	// only the block that owns the current state reaches the transmitter
	assign spi_data     = (state == tft_pkg::DRAW) ? draw_data : init_data;
	assign spi_dc       = (state == tft_pkg::DRAW) ? draw_dc : init_dc;
	assign spi_transmit = ((state == tft_pkg::DRAW) && draw_transmit) ||
	                      ((state == tft_pkg::INIT) && init_transmit);

	assign busy = (state != tft_pkg::IDLE);

	assert property (@(posedge clk) disable iff (!rst)
		!(init_transmit && draw_transmit))
		else $error("init and sprite blocks transmit at the same time");

	// a block signals done only once its last byte has left the transmitter
	assert property (@(posedge clk) disable iff (!rst)
		(state == tft_pkg::IDLE) |-> !spi_busy)
		else $error("transmitter still busy while idle");

endmodule

`default_nettype wire

//--- hdl/maze_display.sv
`timescale 1ns/1ns
`default_nettype none

module maze_display (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      draw,
	input  logic [tft_pkg::POS_W-1:0] player_x,
	input  logic [tft_pkg::POS_W-1:0] player_y,
	output logic                      tft_rst,
	output logic                      tft_clk,
	output logic                      tft_mosi,
	output logic                      tft_dc,
	output logic                      busy
);

	logic [7:0]                init_data;
	logic                      init_dc;
	logic                      init_transmit;
	logic                      init_enable;
	logic                      init_done;
	logic [7:0]                draw_data;
	logic                      draw_dc;
	logic                      draw_transmit;
	logic                      draw_enable;
	logic                      draw_done;
	logic [tft_pkg::POS_W-1:0] draw_x;
	logic [tft_pkg::POS_W-1:0] draw_y;
	logic [7:0]                spi_data;
	logic                      spi_dc;
	logic                      spi_transmit;
	logic                      spi_busy;

	display_ctrl i_ctrl (
		.clk(clk), .rst(rst), .draw(draw), .player_x(player_x), .player_y(player_y),
		.init_done(init_done), .draw_done(draw_done), .spi_busy(spi_busy),
		.init_data(init_data), .init_dc(init_dc), .init_transmit(init_transmit),
		.draw_data(draw_data), .draw_dc(draw_dc), .draw_transmit(draw_transmit),
		.init_enable(init_enable), .draw_enable(draw_enable),
		.draw_x(draw_x), .draw_y(draw_y),
		.spi_data(spi_data), .spi_dc(spi_dc), .spi_transmit(spi_transmit), .busy(busy)
	);

	tft_spi i_spi (
		.clk(clk), .rst(rst), .data(spi_data), .dc(spi_dc), .transmit(spi_transmit),
		.tft_clk(tft_clk), .tft_mosi(tft_mosi), .tft_dc(tft_dc), .busy(spi_busy)
	);

	tft_init i_init (
		.clk(clk), .rst(rst), .enable(init_enable), .tft_busy(spi_busy),
		.tft_data(init_data), .tft_dc(init_dc), .tft_transmit(init_transmit),
		.tft_rst(tft_rst), .done(init_done)
	);

	sprite_draw i_sprite (
		.clk(clk), .rst(rst), .enable(draw_enable), .tft_busy(spi_busy),
		.x(draw_x), .y(draw_y),
		.tft_data(draw_data), .tft_dc(draw_dc), .tft_transmit(draw_transmit),
		.done(draw_done)
	);

endmodule

`default_nettype wire

//--- hdl/sprite_draw.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_draw (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      enable,
	input  logic                      tft_busy,
	input  logic [tft_pkg::POS_W-1:0] x,
	input  logic [tft_pkg::POS_W-1:0] y,
	output logic [7:0]                tft_data,
	output logic                      tft_dc,
	output logic                      tft_transmit,
	output logic                      done
);

	logic [tft_pkg::POS_W-1:0]   x_q;
	logic [tft_pkg::POS_W-1:0]   y_q;
	logic [tft_pkg::COORD_W-1:0] x_start;
	logic [tft_pkg::COORD_W-1:0] x_end;
	logic [tft_pkg::COORD_W-1:0] y_start;
	logic [tft_pkg::COORD_W-1:0] y_end;
	logic [tft_pkg::HDR_W-1:0]   hdr_idx;
	logic [tft_pkg::PIX_W-1:0]   pix;
	logic                        half;      // low byte of the current pixel
	logic                        in_pix;
	logic                        active;
	logic                        pending;
	logic                        seen_busy;
	logic                        pix_on;
	logic [15:0]                 colour;
	logic [7:0]                  pix_byte;
	logic [8:0]                  hdr_word;

	always_ff @(posedge clk) begin
		if (enable) begin
			x_q <= x;
			y_q <= y;
		end
	end

	assign x_start = {{(tft_pkg::COORD_W - tft_pkg::POS_W){1'b0}}, x_q};
	assign y_start = {{(tft_pkg::COORD_W - tft_pkg::POS_W){1'b0}}, y_q};
	assign x_end   = x_start + tft_pkg::SPRITE_SPAN;
	assign y_end   = y_start + tft_pkg::SPRITE_SPAN;

	// row from the upper index bits and the column counted from the msb
	assign pix_on   = tft_pkg::SPRITE_BITMAP[pix[5:3]][~pix[2:0]];
	assign colour   = pix_on ? tft_pkg::PLAYER_COLOR : tft_pkg::BG_COLOR;
	assign pix_byte = half ? colour[7:0] : colour[15:8];

	always_comb begin
		case (hdr_idx)
			4'd0:    hdr_word = {1'b0, tft_pkg::CASET};
			4'd1:    hdr_word = {1'b1, x_start[15:8]};
			4'd2:    hdr_word = {1'b1, x_start[7:0]};
			4'd3:    hdr_word = {1'b1, x_end[15:8]};
			4'd4:    hdr_word = {1'b1, x_end[7:0]};
			4'd5:    hdr_word = {1'b0, tft_pkg::PASET};
			4'd6:    hdr_word = {1'b1, y_start[15:8]};
			4'd7:    hdr_word = {1'b1, y_start[7:0]};
			4'd8:    hdr_word = {1'b1, y_end[15:8]};
			4'd9:    hdr_word = {1'b1, y_end[7:0]};
			default: hdr_word = {1'b0, tft_pkg::RAMWR};
		endcase
	end

	assign {tft_dc, tft_data} = in_pix ? {1'b1, pix_byte} : hdr_word;

	always_ff @(posedge clk) begin
		if (!rst) begin
			tft_transmit <= 1'b0;
			done         <= 1'b0;
			active       <= 1'b0;
			pending      <= 1'b0;
			seen_busy    <= 1'b0;
			in_pix       <= 1'b0;
			half         <= 1'b0;
			hdr_idx      <= '0;
			pix          <= '0;
		end else begin
			done <= 1'b0;
			if (enable) begin
				active    <= 1'b1;
				pending   <= 1'b0;
				seen_busy <= 1'b0;
				in_pix    <= 1'b0;
				half      <= 1'b0;
				hdr_idx   <= '0;
				pix       <= '0;
			end else if (active) begin
				if (tft_transmit) begin
					tft_transmit <= 1'b0;
					pending      <= 1'b1;
				end else if (pending) begin
					if (tft_busy) begin
						seen_busy <= 1'b1;
					end else if (seen_busy) begin
						pending   <= 1'b0;
						seen_busy <= 1'b0;
						if (!in_pix) begin
							if (hdr_idx == tft_pkg::HDR_BYTES - 1'b1) begin
								in_pix <= 1'b1;
							end else begin
								hdr_idx <= hdr_idx + 1'b1;
							end
						end else begin
							half <= !half;
							if (half) begin
								pix <= pix + 1'b1;
								if (&pix) begin
									active <= 1'b0;   // last low byte of the last pixel
									done   <= 1'b1;
								end
							end
						end
					end
				end else begin
					tft_transmit <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/tft_init.sv
`timescale 1ns/1ns
`default_nettype none

module tft_init (
	input  logic       clk,
	input  logic       rst,
	input  logic       enable,
	input  logic       tft_busy,
	output logic [7:0] tft_data,
	output logic       tft_dc,
	output logic       tft_transmit,
	output logic       tft_rst,
	output logic       done
);

	logic [tft_pkg::STEP_W-1:0] step;
	logic [tft_pkg::WAIT_W-1:0] wait_cnt;
	logic                       active;
	logic                       pending;     // byte handed over and not yet finished
	logic                       seen_busy;
	logic                       group_end;   // last byte of a command and its arguments

	// start-up table
	always_comb begin
		case (step)
			3'd0:    {group_end, tft_dc, tft_data} = {2'b10, tft_pkg::SWRESET};
			3'd1:    {group_end, tft_dc, tft_data} = {2'b10, tft_pkg::SLPOUT};
			3'd2:    {group_end, tft_dc, tft_data} = {2'b00, tft_pkg::COLMOD};
			3'd3:    {group_end, tft_dc, tft_data} = {2'b11, tft_pkg::COLMOD_ARG};
			3'd4:    {group_end, tft_dc, tft_data} = {2'b00, tft_pkg::MADCTL};
			3'd5:    {group_end, tft_dc, tft_data} = {2'b11, tft_pkg::MADCTL_ARG};
			3'd6:    {group_end, tft_dc, tft_data} = {2'b10, tft_pkg::DISPON};
			default: {group_end, tft_dc, tft_data} = 10'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			tft_rst      <= 1'b0;
			tft_transmit <= 1'b0;
			done         <= 1'b0;
			active       <= 1'b0;
			pending      <= 1'b0;
			seen_busy    <= 1'b0;
			step         <= '0;
			wait_cnt     <= '0;
		end else begin
			done <= 1'b0;
			if (enable) begin
				active    <= 1'b1;
				tft_rst   <= 1'b0;
				pending   <= 1'b0;
				seen_busy <= 1'b0;
				step      <= '0;
				wait_cnt  <= tft_pkg::RST_LOW_CYCLES;
			end else if (active) begin
				if (wait_cnt != '0) begin
					wait_cnt <= wait_cnt - 1'b1;
				end else if (!tft_rst) begin
					tft_rst  <= 1'b1;   // panel leaves reset and needs time to wake up
					wait_cnt <= tft_pkg::RST_WAIT_CYCLES;
				end else if (tft_transmit) begin
					tft_transmit <= 1'b0;
					pending      <= 1'b1;
				end else if (pending) begin
					if (tft_busy) begin
						seen_busy <= 1'b1;
					end else if (seen_busy) begin
						pending   <= 1'b0;
						seen_busy <= 1'b0;
						step      <= step + 1'b1;
						if (group_end) begin
							wait_cnt <= tft_pkg::CMD_WAIT_CYCLES;
						end
					end
				end else if (step == tft_pkg::INIT_STEPS) begin
					active <= 1'b0;
					done   <= 1'b1;
				end else begin
					tft_transmit <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/tft_pkg.sv
`default_nettype none

package tft_pkg;

	// panel command opcodes, all sent with dc low
	typedef enum logic [7:0] {
		SWRESET = 8'h01,
		SLPOUT  = 8'h11,
		COLMOD  = 8'h3A,
		MADCTL  = 8'h36,
		DISPON  = 8'h29,
		CASET   = 8'h2A,
		PASET   = 8'h2B,
		RAMWR   = 8'h2C
	} tft_cmd_e;

	typedef enum logic [1:0] {
		RESET,
		INIT,
		IDLE,
		DRAW
	} ctrl_state_e;

	localparam int POS_W   = 9;      // sprite coordinate
	localparam int COORD_W = 16;     // coordinate as sent to the panel
	localparam int STEP_W  = 3;      // init table index
	localparam int WAIT_W  = 6;      // must hold the longest init wait
	localparam int HDR_W   = 4;      // window header index
	localparam int PIX_W   = 6;      // pixel index inside the sprite

	localparam int SPRITE_SIZE = 8;

	localparam logic [COORD_W-1:0] SPRITE_SPAN = COORD_W'(SPRITE_SIZE - 1);

	// one row per entry, top row first and msb is the leftmost pixel
	localparam logic [0:SPRITE_SIZE-1][SPRITE_SIZE-1:0] SPRITE_BITMAP = {
		8'b00111100,
		8'b01111110,
		8'b11011011,
		8'b11111111,
		8'b01111110,
		8'b00100100,
		8'b01000010,
		8'b10000001
	};

	localparam logic [15:0] PLAYER_COLOR = 16'hF800;
	localparam logic [15:0] BG_COLOR     = 16'h0000;

	localparam logic [7:0] COLMOD_ARG = 8'h55;   // 16 bits per pixel
	localparam logic [7:0] MADCTL_ARG = 8'h08;   // bgr colour order

	// short counts so that simulation stays quick
	localparam logic [WAIT_W-1:0] RST_LOW_CYCLES  = 6'd20;
	localparam logic [WAIT_W-1:0] RST_WAIT_CYCLES = 6'd40;
	localparam logic [WAIT_W-1:0] CMD_WAIT_CYCLES = 6'd30;

	localparam logic [STEP_W-1:0] INIT_STEPS = 3'd7;   // bytes in the start-up table
	localparam logic [HDR_W-1:0]  HDR_BYTES  = 4'd11;  // window commands up to RAMWR

endpackage

`default_nettype wire

//--- hdl/tft_spi.sv
`timescale 1ns/1ns
`default_nettype none

module tft_spi (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] data,
	input  logic       dc,
	input  logic       transmit,
	output logic       tft_clk,
	output logic       tft_mosi,
	output logic       tft_dc,
	output logic       busy
);

	logic [7:0] shift;
	logic [2:0] bit_cnt;
	logic       phase;     // high half of the spi clock
	logic       armed;     // byte taken and first bit on mosi
	logic       accept;

	assign accept = transmit && !busy && !armed;

	always_ff @(posedge clk) begin
		if (!rst) begin
			busy     <= 1'b0;
			armed    <= 1'b0;
			phase    <= 1'b0;
			bit_cnt  <= 3'd0;
			tft_clk  <= 1'b0;
			tft_mosi <= 1'b0;
			tft_dc   <= 1'b0;
		end else if (accept) begin
			armed    <= 1'b1;
			tft_dc   <= dc;
			tft_mosi <= data[7];   // msb is set up a cycle before the first rise
		end else if (armed) begin
			armed   <= 1'b0;
			busy    <= 1'b1;
			tft_clk <= 1'b1;
			phase   <= 1'b1;
			bit_cnt <= 3'd0;
		end else if (busy) begin
			if (phase) begin
				tft_clk  <= 1'b0;
				phase    <= 1'b0;
				bit_cnt  <= bit_cnt + 3'd1;
				tft_mosi <= shift[6];   // next bit while the clock is low
			end else if (bit_cnt == 3'd0) begin
				busy <= 1'b0;   // counter wrapped so all eight bits are out
			end else begin
				tft_clk <= 1'b1;
				phase   <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			shift <= data;
		end else if (busy && phase) begin
			shift <= {shift[6:0], 1'b0};
		end
	end

	// a source has to wait for the whole byte, including the arming cycle
	assert property (@(posedge clk) disable iff (!rst)
		(busy || armed) |-> !transmit)
		else $error("transmit raised while a byte is in flight");

endmodule

`default_nettype wire

//--- tests/tb_maze_display.sv
`timescale 1ns/1ns
`default_nettype none

module tb_maze_display;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 16;
	localparam int N_ENTRIES    = 6;
	localparam int INIT_BYTES   = 7;
	localparam int DRAW_BYTES   = 139;   // eleven window bytes and 128 pixel bytes
	localparam int WAIT_CYCLES  = RESET_CYCLES + int'(tft_pkg::RST_LOW_CYCLES) +
	                              int'(tft_pkg::RST_WAIT_CYCLES) +
	                              5 * int'(tft_pkg::CMD_WAIT_CYCLES);
	localparam int CYCLE_LIMIT  = (INIT_BYTES + N_ENTRIES * DRAW_BYTES) * 20 +
	                              WAIT_CYCLES + 2000;

	logic                      clk;
	logic                      rst;
	logic                      draw;
	logic [tft_pkg::POS_W-1:0] player_x;
	logic [tft_pkg::POS_W-1:0] player_y;
	logic                      tft_rst;
	logic                      tft_clk;
	logic                      tft_mosi;
	logic                      tft_dc;
	logic                      busy;

	logic [8:0] got_q[$];   // dc followed by the byte, as seen on the pins
	logic [8:0] exp_q[$];

	// stimulus with the expected window end where the last two rows get random positions
	string test_name [N_ENTRIES] = '{"origin", "mid_field", "far_corner", "high_bytes",
	                                 "random_a", "random_b"};
	int    tab_x     [N_ENTRIES] = '{0, 100, 312, 400, 0, 0};
	int    tab_y     [N_ENTRIES] = '{0, 101, 232, 260, 0, 0};
	int    tab_x_end [N_ENTRIES] = '{7, 107, 319, 407, 0, 0};
	int    tab_y_end [N_ENTRIES] = '{7, 108, 239, 267, 0, 0};

	string      cur_test = "init";   // stream that the monitor is collecting
	logic [7:0] shift_in;
	logic       byte_dc;
	int         bit_idx = 0;
	time        first_rise;
	int         cycles = 0;

	maze_display i_dut (
		.clk(clk),
		.rst(rst),
		.draw(draw),
		.player_x(player_x),
		.player_y(player_y),
		.tft_rst(tft_rst),
		.tft_clk(tft_clk),
		.tft_mosi(tft_mosi),
		.tft_dc(tft_dc),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("** Error: %s expected 0x%0h actual 0x%0h",
			                   name, expected, actual));
		end
	endtask

	task automatic add_word(input logic dc, input logic [7:0] b);
		exp_q.push_back({dc, b});
	endtask

	task automatic add_init_words();
		add_word(1'b0, tft_pkg::SWRESET);
		add_word(1'b0, tft_pkg::SLPOUT);
		add_word(1'b0, tft_pkg::COLMOD);
		add_word(1'b1, tft_pkg::COLMOD_ARG);
		add_word(1'b0, tft_pkg::MADCTL);
		add_word(1'b1, tft_pkg::MADCTL_ARG);
		add_word(1'b0, tft_pkg::DISPON);
	endtask

	task automatic add_draw_words(input int x, input int y, input int x_end, input int y_end);
		logic [15:0] xs;
		logic [15:0] xe;
		logic [15:0] ys;
		logic [15:0] ye;
		logic [15:0] colour;
		int          row;
		int          col;
		xs = 16'(x);
		xe = 16'(x_end);
		ys = 16'(y);
		ye = 16'(y_end);
		add_word(1'b0, tft_pkg::CASET);
		add_word(1'b1, xs[15:8]);
		add_word(1'b1, xs[7:0]);
		add_word(1'b1, xe[15:8]);
		add_word(1'b1, xe[7:0]);
		add_word(1'b0, tft_pkg::PASET);
		add_word(1'b1, ys[15:8]);
		add_word(1'b1, ys[7:0]);
		add_word(1'b1, ye[15:8]);
		add_word(1'b1, ye[7:0]);
		add_word(1'b0, tft_pkg::RAMWR);
		for (row = 0; row < tft_pkg::SPRITE_SIZE; row++) begin
			for (col = 0; col < tft_pkg::SPRITE_SIZE; col++) begin
				// leftmost pixel sits in the msb of the row
				if (tft_pkg::SPRITE_BITMAP[row][tft_pkg::SPRITE_SIZE - 1 - col])
					colour = tft_pkg::PLAYER_COLOR;
				else
					colour = tft_pkg::BG_COLOR;
				add_word(1'b1, colour[15:8]);
				add_word(1'b1, colour[7:0]);
			end
		end
	endtask

	task automatic check_reset_pins(input string name);
		check_value({name, " tft_rst"}, 32'd0, tft_rst);
		check_value({name, " tft_clk"}, 32'd0, tft_clk);
		check_value({name, " busy"}, 32'd1, busy);
	endtask

	// starts on a falling edge and gives one ignored draw pulse while busy is still high
	task automatic wait_idle(input int stray_at);
		int n;
		n = 0;
		while (busy !== 1'b0) begin
			draw     = (n == stray_at);
			player_x = '1;
			player_y = '1;
			n++;
			@(negedge clk);
		end
		draw = 1'b0;
	endtask

	task automatic compare_stream(input string name);
		int k;
		check_value({name, " byte count"}, exp_q.size(), got_q.size());
		for (k = 0; k < exp_q.size(); k++) begin
			check_value($sformatf("%s byte %0d", name, k), exp_q[k], got_q[k]);
		end
		exp_q.delete();
		got_q.delete();
	endtask

	// the panel samples one bit on each rising spi edge
	always @(posedge tft_clk) begin
		if (bit_idx == 0) begin
			first_rise = $time;
			byte_dc    = tft_dc;
			check_value({cur_test, " tft_rst at the first bit of a byte"}, 32'd1, tft_rst);
		end
		check_value({cur_test, " tft_dc within a byte"}, byte_dc, tft_dc);
		shift_in = {shift_in[6:0], tft_mosi};
		if (bit_idx == 7) begin
			check_value({cur_test, " first to last bit of a byte in ns"}, 14 * CLK_PERIOD,
			            32'($time - first_rise));
			got_q.push_back({byte_dc, shift_in});
			bit_idx = 0;
		end else begin
			bit_idx++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
			fail_run($sformatf("the run timed out after %0d cycles", CYCLE_LIMIT));
	end

	initial begin
		int i;
		void'($urandom(18741));
		rst      = 1'b0;
		draw     = 1'b0;
		player_x = '0;
		player_y = '0;
		for (i = 4; i < N_ENTRIES; i++) begin
			tab_x[i]     = $urandom % (1 << tft_pkg::POS_W);
			tab_y[i]     = $urandom % (1 << tft_pkg::POS_W);
			tab_x_end[i] = tab_x[i] + tft_pkg::SPRITE_SIZE - 1;
			tab_y_end[i] = tab_y[i] + tft_pkg::SPRITE_SIZE - 1;
		end

		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_reset_pins("in reset");
		end
		rst = 1'b1;
		repeat (int'(tft_pkg::RST_LOW_CYCLES)) begin
			@(negedge clk);
			check_reset_pins("panel reset window");
		end

		wait_idle(200);   // stray pulse lands in the start-up stream
		check_value("tft_rst after start-up", 32'd1, tft_rst);
		add_init_words();
		compare_stream("init");

		for (i = 0; i < N_ENTRIES; i++) begin
			cur_test = test_name[i];
			add_draw_words(tab_x[i], tab_y[i], tab_x_end[i], tab_y_end[i]);
			player_x = tab_x[i][tft_pkg::POS_W-1:0];
			player_y = tab_y[i][tft_pkg::POS_W-1:0];
			draw     = 1'b1;
			@(negedge clk);
			draw = 1'b0;
			check_value({test_name[i], " busy after draw"}, 32'd1, busy);
			wait_idle(1000);
			compare_stream(test_name[i]);
		end

		cur_test = "after the last draw";
		repeat (200) @(negedge clk);
		check_value("bytes after the last draw", 32'd0, got_q.size());
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
